//--- ps2_pkg.sv
package ps2_pkg;

    ////////////////////////////////////////
    // ps2 frame format
    ////////////////////////////////////////

    localparam int PS2_FRAME_BITS = 11;             // start + 8 data + parity + stop

    // scan code set 2 prefix bytes
    localparam logic [7:0] PS2_EXT_PREFIX = 8'hE0;  // extended key follows
    localparam logic [7:0] PS2_BRK_PREFIX = 8'hF0;  // key release follows

    ////////////////////////////////////////
    // key event fifo sizing
    ////////////////////////////////////////

    localparam int EVT_FIFO_DEPTH = 8;              // events held for the cpu
    localparam int EVT_FIFO_AW    = 3;              // slot index bits, ptrs add a wrap bit

    ////////////////////////////////////////
    // scan decoder prefix tracking
    ////////////////////////////////////////

    // one state per prefix combination seen so far
    typedef enum logic [1:0] {
        st_base    = 2'd0,                          // no prefix pending
        st_ext     = 2'd1,                          // E0 seen
        st_brk     = 2'd2,                          // F0 seen
        st_ext_brk = 2'd3                           // E0 then F0 seen
    } scan_state_t;

endpackage

//--- ps2_frame_rx.sv
`timescale 1ns/1ps

module ps2_frame_rx (
    input  logic       clk,
    input  logic       rst_n,                       // sync, active low
    input  logic       ps2_clk,                     // async keyboard clock
    input  logic       ps2_data,                    // async keyboard data
    output logic       byte_valid,                  // one-cycle good byte strobe
    output logic [7:0] byte_data,                   // scan byte, valid with strobe
    output logic       frame_err                    // one-cycle bad frame strobe
);

    ////////////////////////////////////////
    // line synchronizers and edge detect
    ////////////////////////////////////////

    logic [2:0] clk_sync;                           // [1:0] sync pair, [2] last synced
    logic [1:0] data_sync;                          // same depth as clock path
    logic       ps2_fall;                           // keyboard clock fell

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_sync  <= 3'b111;                    // idle high, no false edge
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    assign ps2_fall = clk_sync[2] & ~clk_sync[1];   // older 1, newer 0

    ////////////////////////////////////////
    // bit collection and frame checks
    ////////////////////////////////////////

    logic [3:0]                          bit_cnt;   // bits taken this frame
    logic [ps2_pkg::PS2_FRAME_BITS-2:0] shreg;     // start, data, parity
    logic                                last_bit;  // this edge carries the stop bit
    logic                                frame_ok;

    assign last_bit = (bit_cnt == 4'(ps2_pkg::PS2_FRAME_BITS - 1));

    // stop bit is still on the synced line when checked
    assign frame_ok = (shreg[0] == 1'b0)            // start low
                    && data_sync[1]                 // stop high
                    && (^shreg[9:1]);               // odd parity over data + parity

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt    <= 4'd0;
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;                     // strobes last one cycle
            frame_err  <= 1'b0;
            if (ps2_fall) begin
                if (last_bit) begin
                    byte_valid <= frame_ok;
                    frame_err  <= ~frame_ok;
                    bit_cnt    <= 4'd0;             // ready for next frame
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // lsb first, so the start bit ends up in shreg[0]
    always_ff @(posedge clk) begin
        if (ps2_fall && !last_bit)
            shreg <= {data_sync[1], shreg[ps2_pkg::PS2_FRAME_BITS-2:1]};
        if (ps2_fall && last_bit)
            byte_data <= shreg[8:1];                // data bits only
    end

    // a frame ends in exactly one outcome
    a_one_outcome : assert property (@(posedge clk) disable iff (!rst_n)
        !(byte_valid && frame_err));

endmodule

//--- ps2_scan_decoder.sv
`timescale 1ns/1ps

module ps2_scan_decoder (
    input  logic       clk,
    input  logic       rst_n,                       // sync, active low
    input  logic       byte_valid,                  // good scan byte strobe
    input  logic [7:0] byte_data,                   // scan byte
    output logic       evt_valid,                   // one-cycle key event strobe
    output logic [7:0] evt_code,                    // base scan code
    output logic       evt_ext,                     // E0 preceded the code
    output logic       evt_release                  // F0 preceded the code
);

    ////////////////////////////////////////
    // prefix classification
    ////////////////////////////////////////

    ps2_pkg::scan_state_t state;                    // prefixes collected so far
    logic                 is_ext;                   // byte is E0
    logic                 is_brk;                   // byte is F0
    logic                 is_code;                  // byte ends a key sequence

    assign is_ext  = (byte_data == ps2_pkg::PS2_EXT_PREFIX);
    assign is_brk  = (byte_data == ps2_pkg::PS2_BRK_PREFIX);
    assign is_code = byte_valid && !is_ext && !is_brk;

    ////////////////////////////////////////
    // prefix fsm
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ps2_pkg::st_base;
            evt_valid <= 1'b0;
        end else begin
            evt_valid <= is_code;                   // one cycle after byte strobe
            if (byte_valid) begin
                if (is_ext) begin
                    if (state != ps2_pkg::st_ext_brk)
                        state <= ps2_pkg::st_ext;   // E0 F0 E0 keeps both flags
                end else if (is_brk) begin
                    case (state)
                        ps2_pkg::st_base: state <= ps2_pkg::st_brk;
                        ps2_pkg::st_ext:  state <= ps2_pkg::st_ext_brk;
                        default:          state <= state; // release already noted
                    endcase
                end else begin
                    state <= ps2_pkg::st_base;      // sequence complete
                end
            end
        end
    end

    // event payload, latched only for real codes
    always_ff @(posedge clk) begin
        if (is_code) begin
            evt_code    <= byte_data;
            evt_ext     <= (state == ps2_pkg::st_ext) || (state == ps2_pkg::st_ext_brk);
            evt_release <= (state == ps2_pkg::st_brk) || (state == ps2_pkg::st_ext_brk);
        end
    end

    // prefixes fold into flags and never leave as codes
    a_no_prefix_evt : assert property (@(posedge clk) disable iff (!rst_n)
        evt_valid |-> (evt_code != ps2_pkg::PS2_EXT_PREFIX)
                   && (evt_code != ps2_pkg::PS2_BRK_PREFIX));

endmodule

//--- ps2_event_fifo.sv
`timescale 1ns/1ps

module ps2_event_fifo (
    input  logic       clk,
    input  logic       rst_n,                       // sync, active low
    input  logic       evt_valid,                   // write strobe from decoder
    input  logic [7:0] evt_code,
    input  logic       evt_ext,
    input  logic       evt_release,
    input  logic       rdn,                         // cpu read, active low level
    output logic [7:0] key_code,                    // head entry code
    output logic       key_ext,                     // head entry extended flag
    output logic       key_release,                 // head entry release flag
    output logic       ready,                       // fifo not empty
    output logic       overflow                     // sticky, event was lost
);

    ////////////////////////////////////////
    // storage and pointers
    ////////////////////////////////////////

    logic [9:0]                     mem [ps2_pkg::EVT_FIFO_DEPTH]; // {ext, rel, code}
    logic [ps2_pkg::EVT_FIFO_AW:0]  wr_ptr;         // msb is the wrap bit
    logic [ps2_pkg::EVT_FIFO_AW:0]  rd_ptr;
    logic [ps2_pkg::EVT_FIFO_AW:0]  fill;           // entries held
    logic                           full;
    logic                           wr_en;
    logic                           rd_en;

    assign fill  = wr_ptr - rd_ptr;
    assign full  = (wr_ptr[ps2_pkg::EVT_FIFO_AW] != rd_ptr[ps2_pkg::EVT_FIFO_AW])
                && (wr_ptr[ps2_pkg::EVT_FIFO_AW-1:0] == rd_ptr[ps2_pkg::EVT_FIFO_AW-1:0]);
    assign ready = (wr_ptr != rd_ptr);
    assign wr_en = evt_valid && !full;              // full drops the event
    assign rd_en = !rdn && ready;                   // cpu read on this edge

    ////////////////////////////////////////
    // pointer and flag update
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (evt_valid && full)
                overflow <= 1'b1;                   // lost an event
            if (rd_en) begin
                rd_ptr   <= rd_ptr + 1'b1;
                overflow <= 1'b0;                   // read wins over a drop
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr[ps2_pkg::EVT_FIFO_AW-1:0]] <= {evt_ext, evt_release, evt_code};
    end

    // head shown straight from storage
    assign {key_ext, key_release, key_code} = mem[rd_ptr[ps2_pkg::EVT_FIFO_AW-1:0]];

    // pointers never drift more than one lap apart
    a_fill_bound : assert property (@(posedge clk) disable iff (!rst_n)
        fill <= (ps2_pkg::EVT_FIFO_AW+1)'(ps2_pkg::EVT_FIFO_DEPTH));

endmodule

//--- ps2_kbd.sv
`timescale 1ns/1ps

module ps2_kbd (
    input  logic       clk,
    input  logic       rst_n,                       // sync, active low
    input  logic       ps2_clk,                     // keyboard clock pin
    input  logic       ps2_data,                    // keyboard data pin
    input  logic       rdn,                         // cpu read, active low
    output logic [7:0] key_code,                    // head scan code
    output logic       key_ext,                     // head extended flag
    output logic       key_release,                 // head release flag
    output logic       ready,                       // event available
    output logic       overflow,                    // event lost since last read
    output logic       frame_err                    // bad frame strobe
);

    logic       byte_valid;                         // rx to decoder
    logic [7:0] byte_data;
    logic       evt_valid;                          // decoder to fifo
    logic [7:0] evt_code;
    logic       evt_ext;
    logic       evt_release;

    ////////////////////////////////////////
    // keyboard line receiver
    ////////////////////////////////////////

    ps2_frame_rx i_frame_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .frame_err  (frame_err)
    );

    ps2_scan_decoder i_scan_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .evt_valid   (evt_valid),
        .evt_code    (evt_code),
        .evt_ext     (evt_ext),
        .evt_release (evt_release)
    );

    ////////////////////////////////////////
    // cpu side event queue
    ////////////////////////////////////////

    ps2_event_fifo i_event_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .evt_valid   (evt_valid),
        .evt_code    (evt_code),
        .evt_ext     (evt_ext),
        .evt_release (evt_release),
        .rdn         (rdn),
        .key_code    (key_code),
        .key_ext     (key_ext),
        .key_release (key_release),
        .ready       (ready),
        .overflow    (overflow)
    );

endmodule

//--- tb_ps2_kbd.sv
`timescale 1ns/1ps

module tb_ps2_kbd;

    localparam int CLK_HALF       = 20;             // 40 ns clk
    localparam int RST_CYCLES     = 16;
    localparam int NUM_FRAMES     = 300;
    localparam int HALF_BIT       = 8;              // clk cycles per ps2 clock phase
    localparam int MAX_GAP        = 32;             // idle cycles between frames, max
    localparam int HOLD_FIRST     = 100;            // reader stalls over these frames
    localparam int HOLD_LAST      = 130;
    localparam int TIMEOUT_CYCLES = RST_CYCLES
        + NUM_FRAMES * (ps2_pkg::PS2_FRAME_BITS * 2 * HALF_BIT + MAX_GAP) + 2000;
    localparam logic [31:0] SEED  = 32'd8320;

    logic       clk;
    logic       rst_n;
    logic       ps2_clk;
    logic       ps2_data;
    logic       rdn = 1'b1;                         // reader owns this one
    logic [7:0] key_code;
    logic       key_ext;
    logic       key_release;
    logic       ready;
    logic       overflow;
    logic       frame_err;

    int          cyc        = 0;                    // posedges so far
    int          wr_cyc     = -1;                   // cycle the next event lands in the fifo
    logic [9:0]  wr_evt     = '0;                   // {ext, rel, code}
    int          ferr_cyc   = -1;                   // cycle frame_err must be high
    bit          hold_reads = 1'b0;
    bit          draining   = 1'b0;
    logic [31:0] rd_seed    = SEED ^ 32'h5a5a_5a5a; // own stream for the reader
    logic [9:0]  mq[$];                             // expected fifo contents
    bit          exp_ovf    = 1'b0;
    bit          rd_pend    = 1'b0;                 // read happens on coming posedge
    int          ferr_seen  = 0;
    int          ovf_cycles = 0;
    int          exp_ferr   = 0;
    ps2_pkg::scan_state_t mstate = ps2_pkg::st_base; // prefix model

    ps2_kbd i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .rdn         (rdn),
        .key_code    (key_code),
        .key_ext     (key_ext),
        .key_release (key_release),
        .ready       (ready),
        .overflow    (overflow),
        .frame_err   (frame_err)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [15:0] lcg_next(inout logic [31:0] s);
        s = s * 32'd1103515245 + 32'd12345;
        return s[31:16];                            // upper bits, longer period
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // scan set 2 prefix rules, applied to good bytes only
    task automatic model_byte(input logic [7:0] b, output bit is_evt, output logic [9:0] evt);
        is_evt = 1'b0;
        evt    = '0;
        if (b == ps2_pkg::PS2_EXT_PREFIX) begin
            if (mstate != ps2_pkg::st_ext_brk)
                mstate = ps2_pkg::st_ext;
        end else if (b == ps2_pkg::PS2_BRK_PREFIX) begin
            if (mstate == ps2_pkg::st_base)
                mstate = ps2_pkg::st_brk;
            else if (mstate == ps2_pkg::st_ext)
                mstate = ps2_pkg::st_ext_brk;
        end else begin
            is_evt = 1'b1;
            evt    = {(mstate == ps2_pkg::st_ext) || (mstate == ps2_pkg::st_ext_brk),
                      (mstate == ps2_pkg::st_brk) || (mstate == ps2_pkg::st_ext_brk), b};
            mstate = ps2_pkg::st_base;
        end
    endtask

    // lsb first; data moves only while ps2_clk is high
    task automatic send_frame(input logic [10:0] bits, input bit is_evt,
                              input logic [9:0] evt, input bit bad);
        for (int i = 0; i < ps2_pkg::PS2_FRAME_BITS; i++) begin
            ps2_data = bits[i];
            repeat (HALF_BIT) @(negedge clk);
            ps2_clk = 1'b0;
            if (i == ps2_pkg::PS2_FRAME_BITS - 1) begin
                if (is_evt) begin
                    wr_cyc <= cyc + 5;              // sync 2, rx 1, decoder 1, fifo 1
                    wr_evt <= evt;
                end
                if (bad)
                    ferr_cyc <= cyc + 3;
            end
            repeat (HALF_BIT) @(negedge clk);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;                            // line idle
    endtask

    ////////////////////////////////////////
    // cycle count and timeout
    ////////////////////////////////////////

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > TIMEOUT_CYCLES) begin
            $display("timeout: test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////
    // reader and fifo model
    ////////////////////////////////////////

    always @(negedge clk) begin : reader_model
        logic [9:0]  head;
        logic [15:0] r;

        if (rst_n) begin
            if (cyc == wr_cyc) begin                // write on the posedge just past
                if (mq.size() == ps2_pkg::EVT_FIFO_DEPTH)
                    exp_ovf = 1'b1;                 // event lost
                else
                    mq.push_back(wr_evt);
            end
            if (rd_pend) begin
                void'(mq.pop_front());
                exp_ovf = 1'b0;                     // read clears, even over a drop
            end
            check_val("frame_err", 32'(frame_err), 32'(cyc == ferr_cyc));
            check_val("ready", 32'(ready), 32'(mq.size() != 0));
            check_val("overflow", 32'(overflow), 32'(exp_ovf));
            if (mq.size() != 0) begin
                head = mq[0];
                check_val("key_code", 32'(key_code), 32'(head[7:0]));
                check_val("key_release", 32'(key_release), 32'(head[8]));
                check_val("key_ext", 32'(key_ext), 32'(head[9]));
            end
            if (frame_err)
                ferr_seen++;
            if (exp_ovf)
                ovf_cycles++;
            r = lcg_next(rd_seed);
            if (draining)
                rdn = 1'b0;
            else if (hold_reads)
                rdn = !((cyc + 1 == wr_cyc) && r[5]); // backlog stays, reads meet writes
            else
                rdn = (r[4:0] != 5'd0);             // low about 1 in 32
            rd_pend = !rdn && (mq.size() != 0);
        end else begin
            rdn     = 1'b1;
            rd_pend = 1'b0;
        end
    end

    ////////////////////////////////////////
    // frame stimulus
    ////////////////////////////////////////

    initial begin : stimulus
        logic [31:0] drv_seed;
        logic [15:0] r_byte;
        logic [15:0] r_err;
        logic [15:0] r_gap;
        logic [7:0]  b;
        logic [10:0] frame;
        bit          bad;
        bit          is_evt;
        logic [9:0]  evt;

        drv_seed = SEED;
        rst_n    = 1'b0;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n <= 1'b1;
        repeat (20) @(negedge clk);                 // reads into an empty fifo

        for (int f = 0; f < NUM_FRAMES; f++) begin
            r_byte = lcg_next(drv_seed);
            r_err  = lcg_next(drv_seed);
            r_gap  = lcg_next(drv_seed);
            if (r_byte[1:0] == 2'd0)                // prefix about 1 in 4
                b = r_byte[2] ? ps2_pkg::PS2_EXT_PREFIX : ps2_pkg::PS2_BRK_PREFIX;
            else
                b = r_byte[15:8];
            frame = {1'b1, ~^b, b, 1'b0};           // stop, odd parity, data, start
            bad   = (r_err[2:0] == 3'd0);
            if (bad) begin
                case (r_err[15:8] % 8'd3)
                    8'd0:    frame[9]  = ~frame[9]; // parity
                    8'd1:    frame[0]  = 1'b1;      // start
                    default: frame[10] = 1'b0;      // stop
                endcase
                exp_ferr++;
                is_evt = 1'b0;
                evt    = '0;
            end else begin
                model_byte(b, is_evt, evt);
            end
            hold_reads <= (f >= HOLD_FIRST) && (f < HOLD_LAST);
            send_frame(frame, is_evt, evt, bad);
            repeat (1 + int'(r_gap[4:0])) @(negedge clk);
        end

        draining <= 1'b1;
        while (mq.size() != 0 || cyc <= wr_cyc)
            @(negedge clk);
        repeat (4) @(negedge clk);
        check_val("frame_err_count", 32'(ferr_seen), 32'(exp_ferr));
        check_val("overflow_seen", 32'(ovf_cycles != 0), 32'd1);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- flist.f
ps2_pkg.sv
ps2_frame_rx.sv
ps2_scan_decoder.sv
ps2_event_fifo.sv
ps2_kbd.sv
tb_ps2_kbd.sv

//--- Makefile
# Verilator simulation of the PS/2 keyboard interface

VERILATOR ?= verilator
TOP       ?= tb_ps2_kbd
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG  := SOME TESTS FAILED
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) from $(FLIST), run it, log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
